// File: source/gw_cfg.svh
`ifndef GW_CFG_SVH
`define GW_CFG_SVH

//////////////////////////////////////////////////
// Network shape

// Port 0 faces the IO side, ports 1 to 3 hold the memory endpoints
`define GW_NUM_PORTS 4
`define GW_X_WIDTH 2

//////////////////////////////////////////////////
// Packet payload and memory sizing

`define GW_ADDR_WIDTH 4
`define GW_DATA_WIDTH 16
`define GW_MEM_ELS 16

//////////////////////////////////////////////////
// Tag trace replay

`define GW_ROM_ADDR_WIDTH 4
// One start bit, a 2-bit client number and a 2-bit port payload
`define GW_TAG_FRAME_WIDTH 5

`endif

// File: source/gw_pkg.sv
`include "gw_cfg.svh"

package gw_pkg;

  typedef logic [`GW_X_WIDTH-1:0] gw_x_t;
  typedef logic [$clog2(`GW_NUM_PORTS)-1:0] gw_port_t;
  typedef logic [`GW_ADDR_WIDTH-1:0] gw_addr_t;
  typedef logic [`GW_DATA_WIDTH-1:0] gw_data_t;

  typedef enum logic [1:0]
  {
    e_op_load = 2'd0,
    e_op_store = 2'd1,
    e_op_load_resp = 2'd2,
    e_op_store_ack = 2'd3
  } gw_op_e;

  // Requests and responses share this format on every crossbar link
  typedef struct packed
  {
    gw_op_e op;
    gw_x_t dest_x;
    gw_x_t src_x;
    gw_addr_t addr;
    gw_data_t data;
  } gw_link_pkt_t;

  typedef enum logic [1:0]
  {
    e_trace_nop = 2'd0,
    e_trace_send = 2'd1,
    e_trace_finish = 2'd2
  } gw_trace_op_e;

  // One word of the trace ROM
  typedef struct packed
  {
    gw_trace_op_e op;
    gw_x_t client;
    gw_port_t payload;
  } gw_trace_entry_t;

  // Entry x names the crossbar port that owns coordinate x
  typedef gw_port_t [(1 << `GW_X_WIDTH)-1:0] gw_route_table_t;

  typedef enum logic [1:0] {e_fetch, e_shift, e_done} gw_replay_state_e;

endpackage

// File: source/gw_tag_replay.sv
`include "gw_cfg.svh"

module gw_tag_replay
  (
   input logic blackparrot_clk
  ,input logic rst_i

  ,output logic [`GW_ROM_ADDR_WIDTH-1:0] rom_addr_o
  ,input gw_pkg::gw_trace_entry_t rom_data_i

  ,output logic tag_v_o
  ,output logic tag_bit_o
  ,output logic tag_done_o
  );

  gw_pkg::gw_replay_state_e state_r;
  logic [`GW_ROM_ADDR_WIDTH-1:0] rom_addr_r;
  logic [`GW_TAG_FRAME_WIDTH-1:0] frame_r;
  logic [$clog2(`GW_TAG_FRAME_WIDTH)-1:0] bit_cnt_r;
  logic last_bit;
  logic load_frame;

  assign last_bit = (bit_cnt_r == ($clog2(`GW_TAG_FRAME_WIDTH))'(`GW_TAG_FRAME_WIDTH - 1));
  assign load_frame = (state_r == gw_pkg::e_fetch) && (rom_data_i.op == gw_pkg::e_trace_send);

  //////////////////////////////////////////////////
  // Trace walker

  // Unknown entry ops are skipped like a nop
  always_ff @(posedge blackparrot_clk)
    begin
      if (rst_i)
        begin
          state_r <= gw_pkg::e_fetch;
          rom_addr_r <= '0;
          bit_cnt_r <= '0;
        end
      else
        begin
          case (state_r)
            gw_pkg::e_fetch:
              begin
                if (rom_data_i.op == gw_pkg::e_trace_finish)
                  begin
                    state_r <= gw_pkg::e_done;
                  end
                else
                  begin
                    rom_addr_r <= rom_addr_r + 1'b1;
                    if (load_frame)
                      begin
                        state_r <= gw_pkg::e_shift;
                        bit_cnt_r <= '0;
                      end
                  end
              end
            gw_pkg::e_shift:
              begin
                bit_cnt_r <= bit_cnt_r + 1'b1;
                if (last_bit)
                  state_r <= gw_pkg::e_fetch;
              end
            default:
              begin
                state_r <= gw_pkg::e_done;
              end
          endcase
        end
    end

  // Frame goes out MSB first, so the start bit leads
  always_ff @(posedge blackparrot_clk)
    begin
      if (load_frame)
        frame_r <= {1'b1, rom_data_i.client, rom_data_i.payload};
      else if (state_r == gw_pkg::e_shift)
        frame_r <= frame_r << 1;
    end

  assign rom_addr_o = rom_addr_r;
  assign tag_v_o = (state_r == gw_pkg::e_shift);
  assign tag_bit_o = frame_r[`GW_TAG_FRAME_WIDTH-1];
  assign tag_done_o = (state_r == gw_pkg::e_done);

endmodule

// File: source/gw_tag_master.sv
`include "gw_cfg.svh"

module gw_tag_master
  (
   input logic blackparrot_clk
  ,input logic rst_i

  ,input logic tag_v_i
  ,input logic tag_bit_i

  ,output gw_pkg::gw_route_table_t route_table_o
  );

  logic collecting_r;
  logic [$clog2(`GW_TAG_FRAME_WIDTH-1)-1:0] bit_cnt_r;
  logic [`GW_TAG_FRAME_WIDTH-3:0] shift_r;
  gw_pkg::gw_route_table_t route_r;
  gw_pkg::gw_x_t frame_client;
  gw_pkg::gw_port_t frame_port;
  logic frame_end;

  // The final bit is used straight off the wire so the table updates on that edge
  assign {frame_client, frame_port} = {shift_r, tag_bit_i};
  assign frame_end = collecting_r && tag_v_i && (&bit_cnt_r);

  //////////////////////////////////////////////////
  // Frame collection and table write

  always_ff @(posedge blackparrot_clk)
    begin
      if (rst_i)
        begin
          collecting_r <= 1'b0;
          bit_cnt_r <= '0;
          route_r <= '0;
        end
      else if (!collecting_r)
        begin
          // Idle until a start bit shows up
          if (tag_v_i && tag_bit_i)
            begin
              collecting_r <= 1'b1;
              bit_cnt_r <= '0;
            end
        end
      else if (tag_v_i)
        begin
          bit_cnt_r <= bit_cnt_r + 1'b1;
          if (frame_end)
            begin
              collecting_r <= 1'b0;
              route_r[frame_client] <= frame_port;
            end
        end
    end

  always_ff @(posedge blackparrot_clk)
    begin
      if (collecting_r && tag_v_i)
        shift_r <= {shift_r[`GW_TAG_FRAME_WIDTH-4:0], tag_bit_i};
    end

  assign route_table_o = route_r;

  // Frames arrive as unbroken bursts, a new burst only after the last one finished
  frame_overlap_a: assert property (@(posedge blackparrot_clk) disable iff (rst_i)
    $rose(tag_v_i) |-> !collecting_r)
    else $error("Tag frame started while another frame was being collected");

endmodule

// File: source/gw_link_crossbar.sv
`include "gw_cfg.svh"

module gw_link_crossbar
  (
   input logic blackparrot_clk
  ,input logic rst_i

  ,input gw_pkg::gw_route_table_t route_table_i

  ,input logic [`GW_NUM_PORTS-1:0] in_v_i
  ,input gw_pkg::gw_link_pkt_t [`GW_NUM_PORTS-1:0] in_pkt_i
  ,output logic [`GW_NUM_PORTS-1:0] in_ready_o

  ,output logic [`GW_NUM_PORTS-1:0] out_v_o
  ,output gw_pkg::gw_link_pkt_t [`GW_NUM_PORTS-1:0] out_pkt_o
  ,input logic [`GW_NUM_PORTS-1:0] out_ready_i
  );

  logic active_r;
  gw_pkg::gw_port_t [`GW_NUM_PORTS-1:0] target;
  logic [`GW_NUM_PORTS-1:0][`GW_NUM_PORTS-1:0] req;
  logic [`GW_NUM_PORTS-1:0][`GW_NUM_PORTS-1:0] gnt;
  gw_pkg::gw_port_t [`GW_NUM_PORTS-1:0] gnt_idx;
  logic [`GW_NUM_PORTS-1:0] gnt_any;
  logic [`GW_NUM_PORTS-1:0] out_free;
  logic [`GW_NUM_PORTS-1:0] xfer;
  logic [`GW_NUM_PORTS-1:0] out_v_r;
  gw_pkg::gw_link_pkt_t [`GW_NUM_PORTS-1:0] out_pkt_r;
  gw_pkg::gw_port_t [`GW_NUM_PORTS-1:0] rr_r;

  //////////////////////////////////////////////////
  // Route lookup, req is indexed [output][input]

  always_comb
    begin
      for (int i = 0; i < `GW_NUM_PORTS; i++)
        target[i] = route_table_i[in_pkt_i[i].dest_x];
      for (int o = 0; o < `GW_NUM_PORTS; o++)
        for (int i = 0; i < `GW_NUM_PORTS; i++)
          req[o][i] = in_v_i[i] && (target[i] == gw_pkg::gw_port_t'(o));
    end

  // Round-robin search starts at the input after the last winner
  always_comb
    begin : arb
      gw_pkg::gw_port_t idx;
      gnt = '0;
      gnt_idx = '0;
      gnt_any = '0;
      idx = '0;
      for (int o = 0; o < `GW_NUM_PORTS; o++)
        for (int k = 0; k < `GW_NUM_PORTS; k++)
          begin
            idx = gw_pkg::gw_port_t'(rr_r[o] + k);
            if (!gnt_any[o] && req[o][idx])
              begin
                gnt_any[o] = 1'b1;
                gnt_idx[o] = idx;
                gnt[o][idx] = 1'b1;
              end
          end
    end

  // Ports stay closed for the first cycle after reset
  always_comb
    begin
      for (int o = 0; o < `GW_NUM_PORTS; o++)
        begin
          out_free[o] = active_r && (!out_v_r[o] || out_ready_i[o]);
          xfer[o] = out_free[o] && gnt_any[o];
        end
      for (int i = 0; i < `GW_NUM_PORTS; i++)
        in_ready_o[i] = out_free[target[i]] && gnt[target[i]][i];
    end

  //////////////////////////////////////////////////
  // Output buffers

  always_ff @(posedge blackparrot_clk)
    begin
      if (rst_i)
        begin
          active_r <= 1'b0;
          out_v_r <= '0;
          rr_r <= '0;
        end
      else
        begin
          active_r <= 1'b1;
          for (int o = 0; o < `GW_NUM_PORTS; o++)
            begin
              if (xfer[o])
                begin
                  out_v_r[o] <= 1'b1;
                  rr_r[o] <= gnt_idx[o] + 1'b1;
                end
              else if (out_ready_i[o])
                out_v_r[o] <= 1'b0;
            end
        end
    end

  always_ff @(posedge blackparrot_clk)
    begin
      for (int o = 0; o < `GW_NUM_PORTS; o++)
        if (xfer[o])
          out_pkt_r[o] <= in_pkt_i[gnt_idx[o]];
    end

  assign out_v_o = out_v_r;
  assign out_pkt_o = out_pkt_r;

  for (genvar o = 0; o < `GW_NUM_PORTS; o++)
    begin : chk
      out_hold_a: assert property (@(posedge blackparrot_clk) disable iff (rst_i)
        out_v_o[o] && !out_ready_i[o] |=> out_v_o[o] && $stable(out_pkt_o[o]))
        else $error("Output %0d dropped or changed a packet before it was taken", o);

      one_grant_a: assert property (@(posedge blackparrot_clk) disable iff (rst_i)
        $onehot0(req[o] & in_ready_o))
        else $error("Output %0d accepted more than one input in a cycle", o);
    end

endmodule

// File: source/gw_mem_node.sv
`include "gw_cfg.svh"

module gw_mem_node
  (
   input logic blackparrot_clk
  ,input logic rst_i

  ,input logic req_v_i
  ,input gw_pkg::gw_link_pkt_t req_i
  ,output logic req_ready_o

  ,output logic resp_v_o
  ,output gw_pkg::gw_link_pkt_t resp_o
  ,input logic resp_ready_i
  );

  gw_pkg::gw_data_t mem_r [`GW_MEM_ELS];
  logic resp_v_r;
  gw_pkg::gw_link_pkt_t resp_r;
  logic accept;
  logic is_store;

  // A new request fits whenever the single response slot frees up this cycle
  assign req_ready_o = !resp_v_r || resp_ready_i;
  assign accept = req_v_i && req_ready_o;
  assign is_store = (req_i.op == gw_pkg::e_op_store);

  //////////////////////////////////////////////////
  // Storage

  always_ff @(posedge blackparrot_clk)
    begin
      if (rst_i)
        begin
          for (int i = 0; i < `GW_MEM_ELS; i++)
            mem_r[i] <= '0;
        end
      else if (accept && is_store)
        mem_r[req_i.addr] <= req_i.data;
    end

  //////////////////////////////////////////////////
  // Response register

  always_ff @(posedge blackparrot_clk)
    begin
      if (rst_i)
        resp_v_r <= 1'b0;
      else if (accept)
        resp_v_r <= 1'b1;
      else if (resp_ready_i)
        resp_v_r <= 1'b0;
    end

  // Load data is read before any write on the same edge lands
  always_ff @(posedge blackparrot_clk)
    begin
      if (accept)
        begin
          resp_r.op <= is_store ? gw_pkg::e_op_store_ack : gw_pkg::e_op_load_resp;
          resp_r.dest_x <= req_i.src_x;
          resp_r.src_x <= req_i.dest_x;
          resp_r.addr <= req_i.addr;
          resp_r.data <= is_store ? req_i.data : mem_r[req_i.addr];
        end
    end

  assign resp_v_o = resp_v_r;
  assign resp_o = resp_r;

endmodule

// File: source/gw_top.sv
`include "gw_cfg.svh"

module gw_top
  (
   input logic blackparrot_clk
  ,input logic rst_i

  ,output logic [`GW_ROM_ADDR_WIDTH-1:0] rom_addr_o
  ,input gw_pkg::gw_trace_entry_t rom_data_i
  ,output logic tag_done_o

  ,input logic req_v_i
  ,input gw_pkg::gw_link_pkt_t req_i
  ,output logic req_ready_o

  ,output logic resp_v_o
  ,output gw_pkg::gw_link_pkt_t resp_o
  ,input logic resp_ready_i
  );

  logic tag_v;
  logic tag_bit;
  logic tag_done;
  logic net_rst;
  gw_pkg::gw_route_table_t route_table;

  logic [`GW_NUM_PORTS-1:0] xb_in_v;
  gw_pkg::gw_link_pkt_t [`GW_NUM_PORTS-1:0] xb_in_pkt;
  logic [`GW_NUM_PORTS-1:0] xb_in_ready;
  logic [`GW_NUM_PORTS-1:0] xb_out_v;
  gw_pkg::gw_link_pkt_t [`GW_NUM_PORTS-1:0] xb_out_pkt;
  logic [`GW_NUM_PORTS-1:0] xb_out_ready;

  // Network and memories sit in reset until the route table is loaded
  assign net_rst = rst_i | ~tag_done;
  assign tag_done_o = tag_done;

  //////////////////////////////////////////////////
  // Tag path

  gw_tag_replay replay
    (.blackparrot_clk(blackparrot_clk)
    ,.rst_i(rst_i)
    ,.rom_addr_o(rom_addr_o)
    ,.rom_data_i(rom_data_i)
    ,.tag_v_o(tag_v)
    ,.tag_bit_o(tag_bit)
    ,.tag_done_o(tag_done)
    );

  gw_tag_master master
    (.blackparrot_clk(blackparrot_clk)
    ,.rst_i(rst_i)
    ,.tag_v_i(tag_v)
    ,.tag_bit_i(tag_bit)
    ,.route_table_o(route_table)
    );

  //////////////////////////////////////////////////
  // Network

  gw_link_crossbar network
    (.blackparrot_clk(blackparrot_clk)
    ,.rst_i(net_rst)
    ,.route_table_i(route_table)
    ,.in_v_i(xb_in_v)
    ,.in_pkt_i(xb_in_pkt)
    ,.in_ready_o(xb_in_ready)
    ,.out_v_o(xb_out_v)
    ,.out_pkt_o(xb_out_pkt)
    ,.out_ready_i(xb_out_ready)
    );

  // Port 0 is the external IO port
  assign xb_in_v[0] = req_v_i;
  assign xb_in_pkt[0] = req_i;
  assign req_ready_o = xb_in_ready[0];
  assign resp_v_o = xb_out_v[0];
  assign resp_o = xb_out_pkt[0];
  assign xb_out_ready[0] = resp_ready_i;

  for (genvar i = 1; i < `GW_NUM_PORTS; i++)
    begin : mem
      gw_mem_node node
        (.blackparrot_clk(blackparrot_clk)
        ,.rst_i(net_rst)
        ,.req_v_i(xb_out_v[i])
        ,.req_i(xb_out_pkt[i])
        ,.req_ready_o(xb_out_ready[i])
        ,.resp_v_o(xb_in_v[i])
        ,.resp_o(xb_in_pkt[i])
        ,.resp_ready_i(xb_in_ready[i])
        );
    end

endmodule

// File: verif/gw_tb.sv
`include "gw_cfg.svh"

module gw_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 1000;

  logic blackparrot_clk;
  logic rst_i;
  logic [`GW_ROM_ADDR_WIDTH-1:0] rom_addr;
  gw_pkg::gw_trace_entry_t rom_data;
  logic tag_done_o;
  logic req_v_i;
  gw_pkg::gw_link_pkt_t req_i;
  logic req_ready_o;
  logic resp_v_o;
  gw_pkg::gw_link_pkt_t resp_o;
  logic resp_ready_i;

  integer seed;
  logic stall_en;
  string test_name;

  // Reference memory and pending responses, both indexed by the memory's x coordinate
  gw_pkg::gw_data_t model_mem [4][`GW_MEM_ELS];
  gw_pkg::gw_link_pkt_t exp_q [4][$];

  gw_top uut
    (.blackparrot_clk(blackparrot_clk)
    ,.rst_i(rst_i)
    ,.rom_addr_o(rom_addr)
    ,.rom_data_i(rom_data)
    ,.tag_done_o(tag_done_o)
    ,.req_v_i(req_v_i)
    ,.req_i(req_i)
    ,.req_ready_o(req_ready_o)
    ,.resp_v_o(resp_v_o)
    ,.resp_o(resp_o)
    ,.resp_ready_i(resp_ready_i)
    );

  always #50 blackparrot_clk = ~blackparrot_clk;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "Stopping at first failure");
  endtask

  function automatic gw_pkg::gw_trace_entry_t make_entry(input gw_pkg::gw_trace_op_e op,
                                                          input gw_pkg::gw_x_t client,
                                                          input gw_pkg::gw_port_t port);
    gw_pkg::gw_trace_entry_t e;
    e.op = op;
    e.client = client;
    e.payload = port;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Trace ROM

  // Two idle entries, then one route per coordinate, then the end marker
  always_comb
    begin
      case (rom_addr)
        4'd2: rom_data = make_entry(gw_pkg::e_trace_send, 2'd0, 2'd0);
        4'd3: rom_data = make_entry(gw_pkg::e_trace_send, 2'd1, 2'd3);
        4'd4: rom_data = make_entry(gw_pkg::e_trace_send, 2'd2, 2'd2);
        4'd5: rom_data = make_entry(gw_pkg::e_trace_send, 2'd3, 2'd1);
        4'd6: rom_data = make_entry(gw_pkg::e_trace_finish, 2'd0, 2'd0);
        default: rom_data = make_entry(gw_pkg::e_trace_nop, 2'd0, 2'd0);
      endcase
    end

  // Response stalls change just after the edge, like every other input
  always @(posedge blackparrot_clk)
    begin : stall_gen
      logic [31:0] r;
      r = $random(seed);
      #1;
      resp_ready_i = stall_en ? r[0] : 1'b1;
    end

  //////////////////////////////////////////////////
  // Checkers

  always @(negedge blackparrot_clk)
    begin : monitor
      gw_pkg::gw_link_pkt_t exp;
      if (tag_done_o !== 1'b1)
        assert (req_ready_o !== 1'b1 && resp_v_o !== 1'b1)
          else report_failure("IO port became active before the route table was loaded");
      if (resp_v_o === 1'b1 && resp_ready_i)
        begin
          assert (exp_q[resp_o.src_x].size() > 0)
            else report_failure($sformatf("Extra response arrived from x%0d", resp_o.src_x));
          exp = exp_q[resp_o.src_x].pop_front();
          assert (resp_o == exp)
            else report_failure($sformatf("Mismatch test=%s expected=%h actual=%h",
                                          test_name, exp, resp_o));
        end
    end

  // Called just after a rising edge, returns just after the edge that took the request
  task automatic send_req(input gw_pkg::gw_op_e op, input gw_pkg::gw_x_t x,
                          input gw_pkg::gw_addr_t addr, input gw_pkg::gw_data_t data);
    gw_pkg::gw_link_pkt_t exp;
    int cycles;
    exp.dest_x = 2'd0;
    exp.src_x = x;
    exp.addr = addr;
    if (op == gw_pkg::e_op_store)
      begin
        exp.op = gw_pkg::e_op_store_ack;
        exp.data = data;
        model_mem[x][addr] = data;
      end
    else
      begin
        exp.op = gw_pkg::e_op_load_resp;
        exp.data = model_mem[x][addr];
      end
    exp_q[x].push_back(exp);
    req_i.op = op;
    req_i.dest_x = x;
    req_i.src_x = 2'd0;
    req_i.addr = addr;
    req_i.data = data;
    req_v_i = 1'b1;
    cycles = 0;
    @(negedge blackparrot_clk);
    while (!req_ready_o)
      begin
        cycles++;
        if (cycles > timeout_cycles)
          report_failure($sformatf("Request to x%0d was never accepted", x));
        @(negedge blackparrot_clk);
      end
    @(posedge blackparrot_clk);
    #1;
    req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0)
      begin
        cycles++;
        if (cycles > timeout_cycles)
          report_failure($sformatf("Responses still missing after %0d cycles", cycles));
        @(negedge blackparrot_clk);
      end
    // A few quiet cycles so a duplicate response would still be caught
    repeat (4) @(posedge blackparrot_clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  initial
    begin : stimulus
      int cycles;
      logic [31:0] r;
      gw_pkg::gw_data_t d;
      seed = 5472;
      blackparrot_clk = 1'b0;
      rst_i = 1'b1;
      req_v_i = 1'b0;
      req_i = '0;
      resp_ready_i = 1'b1;
      stall_en = 1'b0;
      for (int x = 0; x < 4; x++)
        for (int a = 0; a < `GW_MEM_ELS; a++)
          model_mem[x][a] = '0;

      test_name = "reset_gating";
      repeat (4) @(posedge blackparrot_clk);
      #1;
      rst_i = 1'b0;
      // A load waits at the IO port through the replay, so an early ready would show
      req_i.op = gw_pkg::e_op_load;
      req_i.dest_x = 2'd1;
      req_i.src_x = 2'd0;
      req_i.addr = 4'd0;
      req_i.data = '0;
      req_v_i = 1'b1;
      cycles = 0;
      while (tag_done_o !== 1'b1)
        begin
          cycles++;
          if (cycles > timeout_cycles)
            report_failure("Tag replay never signalled done");
          @(posedge blackparrot_clk);
          #1;
        end
      send_req(gw_pkg::e_op_load, 2'd1, 4'd0, '0);

      test_name = "store_ack";
      for (int x = 1; x < 4; x++)
        begin
          d = gw_pkg::gw_data_t'($random(seed));
          send_req(gw_pkg::e_op_store, gw_pkg::gw_x_t'(x), 4'd3, d);
        end
      wait_drain();

      // Address 9 was never written, so its load must come back zero
      test_name = "load_after_store";
      send_req(gw_pkg::e_op_load, 2'd1, 4'd3, '0);
      send_req(gw_pkg::e_op_load, 2'd2, 4'd9, '0);
      send_req(gw_pkg::e_op_load, 2'd3, 4'd3, '0);
      wait_drain();

      test_name = "separate_memories";
      d = gw_pkg::gw_data_t'($random(seed));
      send_req(gw_pkg::e_op_store, 2'd1, 4'd7, d);
      send_req(gw_pkg::e_op_store, 2'd2, 4'd7, d ^ 16'h00ff);
      send_req(gw_pkg::e_op_store, 2'd3, 4'd7, d ^ 16'hff00);
      for (int x = 1; x < 4; x++)
        send_req(gw_pkg::e_op_load, gw_pkg::gw_x_t'(x), 4'd7, '0);
      wait_drain();

      test_name = "back_pressure";
      stall_en = 1'b1;
      for (int n = 0; n < 60; n++)
        begin
          r = $random(seed);
          send_req(r[0] ? gw_pkg::e_op_store : gw_pkg::e_op_load,
                   gw_pkg::gw_x_t'(1 + (r[15:8] % 3)), r[7:4], r[31:16]);
        end
      wait_drain();
      stall_en = 1'b0;

      $display("All tests passed!");
      $finish;
    end

endmodule

// File: gw_top.f
+incdir+source
source/gw_pkg.sv
source/gw_tag_replay.sv
source/gw_tag_master.sv
source/gw_link_crossbar.sv
source/gw_mem_node.sv
source/gw_top.sv
verif/gw_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gw_tb -f gw_top.f -o gw_sim

sim_out=$(./obj_dir/gw_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1
